//--- common/cnn_pkg.sv
`default_nettype none

package cnn_pkg;

    // word and kernel geometry
    localparam int data_width      = 16;   // float16, stored bit-exact
    localparam int kernel_size_max = 3;
    localparam int slice_words     = kernel_size_max * kernel_size_max;

    // bank organisation, one bank per output channel
    localparam int para_y     = 4;
    localparam int bank_depth = 16;
    localparam int row_width  = 4;
    localparam int bank_width = 2;

    // command fields
    localparam int fm_size_width = 10;
    localparam int pos_width     = $clog2(slice_words);         // flat position in a slice
    localparam int ks_width      = $clog2(kernel_size_max + 1); // kernel_size 1..3

    // credit flow control on both streams
    localparam int in_credits   = 4;    // loader buffer depth
    localparam int out_credits  = 4;
    localparam int in_ptr_width = $clog2(in_credits);
    localparam int in_cnt_width = $clog2(in_credits + 1);
    localparam int credit_width = $clog2(out_credits + 1);

    // read modes
    localparam logic mode_conv = 1'b0;
    localparam logic mode_fc   = 1'b1;

    // one kernel slice, seen either as a 3x3 grid or as nine values in a row
    // kernel[r][c] sits on the same bits as flat[3r+c]
    typedef union packed {
        logic [kernel_size_max-1:0][kernel_size_max-1:0][data_width-1:0] kernel;
        logic [slice_words-1:0][data_width-1:0]                          flat;
    } weight_slice_u;

endpackage

`default_nettype wire

//--- weight_ram/weight_ram_float16.sv
`timescale 1ns/10ps
`default_nettype none

module weight_ram_float16 (
    input  logic                                          clk,
    input  logic                                          arst_n,
    input  logic                                          wr_en,
    input  logic [cnn_pkg::bank_width-1:0]                wr_bank,
    input  logic [cnn_pkg::row_width-1:0]                 wr_row,
    input  cnn_pkg::weight_slice_u                        wr_slice,
    input  logic                                          rd_en,
    input  logic [cnn_pkg::row_width-1:0]                 rd_row,
    input  logic [cnn_pkg::pos_width-1:0]                 rd_pos,
    output logic                                          rd_stall,
    output logic [cnn_pkg::para_y*cnn_pkg::data_width-1:0] rd_data,
    output logic                                          rd_valid
);

    import cnn_pkg::*;

    logic read_go;  // read actually performed this cycle

    // single port, the write takes the cycle and the reader retries
    assign rd_stall = rd_en && wr_en;
    assign read_go  = rd_en && !wr_en;

    genvar b;
    generate
        for (b = 0; b < para_y; b++) begin : g_bank
            weight_slice_u          bank_mem [bank_depth];
            logic [data_width-1:0]  rd_word_q;
            logic                   bank_sel;

            assign bank_sel = (wr_bank == bank_width'(b));

            // slice rows of one output channel
            always_ff @(posedge clk) begin
                if (wr_en && bank_sel) begin
                    bank_mem[wr_row] <= wr_slice;
                end
                if (read_go) begin
                    // every lane reads the same row and position
                    rd_word_q <= bank_mem[rd_row].flat[rd_pos];
                end
            end

            assign rd_data[b*data_width +: data_width] = rd_word_q;
        end
    endgenerate

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= read_go;    // data lands one cycle after the request
        end
    end

    // the issuer only ever asks for a position inside a slice
    a_pos_in_slice: assert property (@(posedge clk) disable iff (!arst_n)
        rd_en |-> (rd_pos < pos_width'(slice_words)))
        else $error("weight_ram_float16: rd_pos %0d past slice end", rd_pos);

    // a stalled request is held and repeated on the next cycle
    a_stall_retry: assert property (@(posedge clk) disable iff (!arst_n)
        rd_stall |=> (rd_en && $stable(rd_row) && $stable(rd_pos)))
        else $error("weight_ram_float16: stalled read was not retried");

endmodule

`default_nettype wire

//--- weight_ram/weight_loader.sv
`timescale 1ns/10ps
`default_nettype none

module weight_loader (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             in_valid,
    input  logic [cnn_pkg::data_width-1:0]   in_data,
    output logic                             in_credit,
    input  logic                             load_start,
    input  logic [cnn_pkg::row_width-1:0]    wr_base_row,
    input  logic [cnn_pkg::bank_width-1:0]   wr_base_bank,
    output logic                             wr_en,
    output logic [cnn_pkg::bank_width-1:0]   wr_bank,
    output logic [cnn_pkg::row_width-1:0]    wr_row,
    output cnn_pkg::weight_slice_u           wr_slice
);

    import cnn_pkg::*;

    logic [data_width-1:0]   fifo_mem [in_credits];
    logic [in_ptr_width-1:0] wp_q;
    logic [in_ptr_width-1:0] rp_q;
    logic [in_cnt_width-1:0] fill_q;
    logic                    pop;
    logic [pos_width-1:0]    word_q;
    logic [pos_width-1:0]    word_idx;
    logic                    base_pend_q;  // take the base address after reset

    assign pop      = (fill_q != '0);   // drain one word per cycle
    assign word_idx = load_start ? '0 : word_q;  // restart puts this word first

    always_ff @(posedge clk) begin
        if (in_valid) begin
            fifo_mem[wp_q] <= in_data;
        end
        if (pop) begin
            wr_slice.flat[word_idx] <= fifo_mem[rp_q];
        end
    end

    // buffer pointers and credit return
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wp_q      <= '0;
            rp_q      <= '0;
            fill_q    <= '0;
            in_credit <= 1'b0;
        end else begin
            if (in_valid) wp_q <= wp_q + 1'b1;
            if (pop) rp_q <= rp_q + 1'b1;
            case ({in_valid, pop})
                2'b10:   fill_q <= fill_q + 1'b1;
                2'b01:   fill_q <= fill_q - 1'b1;
                default: fill_q <= fill_q;
            endcase
            in_credit <= pop;   // one credit back per word taken out
        end
    end

    // slice assembly and bank/row walk
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            word_q      <= '0;
            wr_en       <= 1'b0;
            wr_bank     <= '0;
            wr_row      <= '0;
            base_pend_q <= 1'b1;
        end else begin
            base_pend_q <= 1'b0;
            wr_en       <= 1'b0;
            if (pop) begin
                if (word_idx == pos_width'(slice_words - 1)) begin
                    word_q <= '0;
                    wr_en  <= 1'b1;   // ninth word, write the slice next cycle
                end else begin
                    word_q <= word_idx + 1'b1;
                end
            end else if (load_start) begin
                word_q <= '0;
            end

            if (base_pend_q || load_start) begin
                wr_bank <= wr_base_bank;
                wr_row  <= wr_base_row;
            end else if (wr_en) begin
                // slices go round the banks, then down one row
                if (wr_bank == bank_width'(para_y - 1)) begin
                    wr_bank <= '0;
                    wr_row  <= wr_row + 1'b1;
                end else begin
                    wr_bank <= wr_bank + 1'b1;
                end
            end
        end
    end

    // host sends only against credits it holds
    a_no_overrun: assert property (@(posedge clk) disable iff (!arst_n)
        in_valid |-> (fill_q != in_cnt_width'(in_credits)))
        else $error("weight_loader: word arrived with buffer full");

endmodule

`default_nettype wire

//--- rtl/weight_issue.sv
`timescale 1ns/10ps
`default_nettype none

module weight_issue (
    input  logic                                           clk,
    input  logic                                           arst_n,
    input  logic                                           start,
    input  logic                                           mode,
    input  logic [cnn_pkg::ks_width-1:0]                   kernel_size,
    input  logic [cnn_pkg::row_width-1:0]                  base_row,
    input  logic [cnn_pkg::fm_size_width-1:0]              fm_total_size,
    output logic                                           busy,
    output logic                                           rd_en,
    output logic [cnn_pkg::row_width-1:0]                  rd_row,
    output logic [cnn_pkg::pos_width-1:0]                  rd_pos,
    input  logic                                           rd_stall,
    input  logic [cnn_pkg::para_y*cnn_pkg::data_width-1:0] rd_data,
    input  logic                                           rd_valid,
    output logic                                           out_valid,
    output logic [cnn_pkg::para_y*cnn_pkg::data_width-1:0] out_data,
    output logic                                           out_last,
    input  logic                                           out_credit
);

    import cnn_pkg::*;

    weight_slice_u             pos_map;    // flat index stored in every word
    logic                      walk_q;     // reads still to issue
    logic                      mode_q;
    logic [ks_width-1:0]       ks_q;
    logic [ks_width-1:0]       r_q;
    logic [ks_width-1:0]       c_q;
    logic [row_width-1:0]      row_q;
    logic [fm_size_width-1:0]  total_q;
    logic [fm_size_width-1:0]  idx_q;      // FC index, 0..total-1
    logic [pos_width-1:0]      fc_pos_q;   // idx_q mod 9 without a divider
    logic [pos_width-1:0]      conv_pos;
    logic [credit_width-1:0]   credit_q;
    logic                      accept;
    logic                      is_last;
    logic                      is_pad;
    logic                      last_q;
    logic                      pad_q;
    logic                      busy_tail_q;  // reads issued, last beat not yet out

    // kernel view of this table gives the flat position of (r, c)
    always_comb begin
        for (int i = 0; i < slice_words; i++) begin
            pos_map.flat[i] = data_width'(i);
        end
    end

    assign conv_pos = pos_map.kernel[r_q][c_q][pos_width-1:0];

    assign rd_en  = walk_q && (credit_q != '0);  // no credit, no read
    assign rd_row = row_q;
    assign rd_pos = (mode_q == mode_conv) ? conv_pos : fc_pos_q;
    assign accept = rd_en && !rd_stall;

    assign is_last = (mode_q == mode_conv) ?
                     ((r_q == ks_q - 1'b1) && (c_q == ks_q - 1'b1)) :
                     ((idx_q + fm_size_width'(1)) >= total_q);

    // a zero-length FC command still yields one beat, all zero
    assign is_pad = (mode_q == mode_fc) && (idx_q >= total_q);

    assign busy      = walk_q || busy_tail_q;
    assign out_valid = rd_valid;
    assign out_last  = rd_valid && last_q;
    assign out_data  = pad_q ? '0 : rd_data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            walk_q      <= 1'b0;
            busy_tail_q <= 1'b0;
            mode_q      <= mode_conv;
            ks_q        <= ks_width'(1);
            r_q         <= '0;
            c_q         <= '0;
            row_q       <= '0;
            total_q     <= '0;
            idx_q       <= '0;
            fc_pos_q    <= '0;
            last_q      <= 1'b0;
            pad_q       <= 1'b0;
            credit_q    <= credit_width'(out_credits);
        end else begin
            credit_q <= credit_q - credit_width'(accept) + credit_width'(out_credit);
            if (accept) begin
                last_q <= is_last;  // tags travel with the read
                pad_q  <= is_pad;
            end
            if (out_last) begin
                busy_tail_q <= 1'b0;
            end

            if (start && !busy) begin
                walk_q   <= 1'b1;
                mode_q   <= mode;
                ks_q     <= kernel_size;
                row_q    <= base_row;
                total_q  <= fm_total_size;
                r_q      <= '0;
                c_q      <= '0;
                idx_q    <= '0;
                fc_pos_q <= '0;
            end else if (accept) begin
                if (is_last) begin
                    walk_q      <= 1'b0;
                    busy_tail_q <= 1'b1;
                end else if (mode_q == mode_conv) begin
                    if (c_q == ks_q - 1'b1) begin   // row-major over the kernel
                        c_q <= '0;
                        r_q <= r_q + 1'b1;
                    end else begin
                        c_q <= c_q + 1'b1;
                    end
                end else begin
                    idx_q <= idx_q + 1'b1;
                    if (fc_pos_q == pos_width'(slice_words - 1)) begin
                        fc_pos_q <= '0;
                        row_q    <= row_q + 1'b1;   // next slice row
                    end else begin
                        fc_pos_q <= fc_pos_q + 1'b1;
                    end
                end
            end
        end
    end

    // downstream returns only credits it was given
    a_credit_bound: assert property (@(posedge clk) disable iff (!arst_n)
        credit_q <= credit_width'(out_credits))
        else $error("weight_issue: credit count %0d over limit", credit_q);

endmodule

`default_nettype wire

//--- rtl/weight_buffer_top.sv
`timescale 1ns/10ps
`default_nettype none

module weight_buffer_top (
    input  logic                                           clk,
    input  logic                                           arst_n,
    // weight input stream
    input  logic                                           in_valid,
    input  logic [cnn_pkg::data_width-1:0]                 in_data,
    output logic                                           in_credit,
    input  logic                                           load_start,
    input  logic [cnn_pkg::row_width-1:0]                  wr_base_row,
    input  logic [cnn_pkg::bank_width-1:0]                 wr_base_bank,
    // read commands
    input  logic                                           start,
    input  logic                                           mode,
    input  logic [cnn_pkg::ks_width-1:0]                   kernel_size,
    input  logic [cnn_pkg::row_width-1:0]                  base_row,
    input  logic [cnn_pkg::fm_size_width-1:0]              fm_total_size,
    output logic                                           busy,
    // weight output stream
    output logic                                           out_valid,
    output logic [cnn_pkg::para_y*cnn_pkg::data_width-1:0] out_data,
    output logic                                           out_last,
    input  logic                                           out_credit
);

    import cnn_pkg::*;

    logic                          wr_en;
    logic [bank_width-1:0]         wr_bank;
    logic [row_width-1:0]          wr_row;
    weight_slice_u                 wr_slice;
    logic                          rd_en;
    logic [row_width-1:0]          rd_row;
    logic [pos_width-1:0]          rd_pos;
    logic                          rd_stall;
    logic [para_y*data_width-1:0]  rd_data;
    logic                          rd_valid;

    weight_loader u_loader (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .in_data      (in_data),
        .in_credit    (in_credit),
        .load_start   (load_start),
        .wr_base_row  (wr_base_row),
        .wr_base_bank (wr_base_bank),
        .wr_en        (wr_en),
        .wr_bank      (wr_bank),
        .wr_row       (wr_row),
        .wr_slice     (wr_slice)
    );

    weight_ram_float16 u_ram (
        .clk      (clk),
        .arst_n   (arst_n),
        .wr_en    (wr_en),
        .wr_bank  (wr_bank),
        .wr_row   (wr_row),
        .wr_slice (wr_slice),
        .rd_en    (rd_en),
        .rd_row   (rd_row),
        .rd_pos   (rd_pos),
        .rd_stall (rd_stall),
        .rd_data  (rd_data),
        .rd_valid (rd_valid)
    );

    weight_issue u_issue (
        .clk           (clk),
        .arst_n        (arst_n),
        .start         (start),
        .mode          (mode),
        .kernel_size   (kernel_size),
        .base_row      (base_row),
        .fm_total_size (fm_total_size),
        .busy          (busy),
        .rd_en         (rd_en),
        .rd_row        (rd_row),
        .rd_pos        (rd_pos),
        .rd_stall      (rd_stall),
        .rd_data       (rd_data),
        .rd_valid      (rd_valid),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .out_last      (out_last),
        .out_credit    (out_credit)
    );

endmodule

`default_nettype wire

//--- tests/clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

module clk_gen (
    output logic clk,
    output logic arst_n
);

    localparam int half_period = 50;  // 100 ns clock

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // reset held over the first two rising edges, released mid-cycle
    initial begin
        arst_n = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- tests/weight_buffer_tb.sv
`timescale 1ns/10ps
`default_nettype none

module weight_buffer_tb;

    import cnn_pkg::*;

    localparam int beat_width = para_y * data_width;
    localparam int max_cycles = 4000;  // whole run is a few hundred cycles

    logic                      clk;
    logic                      arst_n;
    logic                      in_valid;
    logic [data_width-1:0]     in_data;
    logic                      in_credit;
    logic                      load_start;
    logic [row_width-1:0]      wr_base_row;
    logic [bank_width-1:0]     wr_base_bank;
    logic                      start;
    logic                      mode;
    logic [ks_width-1:0]       kernel_size;
    logic [row_width-1:0]      base_row;
    logic [fm_size_width-1:0]  fm_total_size;
    logic                      busy;
    logic                      out_valid;
    logic [beat_width-1:0]     out_data;
    logic                      out_last;
    logic                      out_credit;

    logic [data_width-1:0] model [para_y][bank_depth][slice_words];  // expected bank contents
    int          host_credits;
    int          errors = 0;
    int          tests_run = 0;
    int          beats_checked = 0;
    int          cycle_count = 0;
    int          stall_count = 0;

    clk_gen u_clk (.clk(clk), .arst_n(arst_n));

    weight_buffer_top uut (
        .clk(clk), .arst_n(arst_n),
        .in_valid(in_valid), .in_data(in_data), .in_credit(in_credit),
        .load_start(load_start), .wr_base_row(wr_base_row), .wr_base_bank(wr_base_bank),
        .start(start), .mode(mode), .kernel_size(kernel_size), .base_row(base_row),
        .fm_total_size(fm_total_size), .busy(busy),
        .out_valid(out_valid), .out_data(out_data), .out_last(out_last),
        .out_credit(out_credit)
    );

    // watchdog and collision counter, sampled away from the driving edge
    always @(negedge clk) begin
        cycle_count = cycle_count + 1;
        if (arst_n && uut.rd_stall) stall_count = stall_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("timeout: run still going after %0d cycles", max_cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic note_mismatch(input string name, input logic [beat_width-1:0] got,
                                 input logic [beat_width-1:0] exp);
        errors++;
        $display("mismatch %s: got %h expected %h (cycle %0d)", name, got, exp, cycle_count);
    endtask

    task automatic note_failure(input string what);
        errors++;
        $display("error: %s (cycle %0d)", what, cycle_count);
    endtask

    // beat idx of a command, built from the bank model
    function automatic logic [beat_width-1:0] expected_beat(input logic cmd_mode, input int ks,
                                                            input int row, input int total,
                                                            input int idx);
        logic [beat_width-1:0] beat;
        int r;
        int pos;
        if (cmd_mode == mode_conv) begin
            r   = row;
            pos = (idx / ks) * kernel_size_max + (idx % ks);  // row-major kernel walk
        end else begin
            r   = row + idx / slice_words;
            pos = idx % slice_words;
        end
        for (int b = 0; b < para_y; b++) begin
            if (cmd_mode == mode_fc && idx >= total) beat[b*data_width +: data_width] = '0;
            else beat[b*data_width +: data_width] = model[b][r % bank_depth][pos];
        end
        return beat;
    endfunction

    // sends n_slices of random words against host credits, then checks credit return
    task automatic load_slices(input int n_slices, input int row0, input int bank0);
        int n_words;
        int sent;
        int returned;
        int extra;
        int slot;
        logic [data_width-1:0] w;
        n_words  = n_slices * slice_words;
        sent     = 0;
        returned = 0;
        extra    = 0;
        @(posedge clk);
        load_start   <= 1'b1;
        wr_base_row  <= row_width'(row0);
        wr_base_bank <= bank_width'(bank0);
        @(posedge clk);
        load_start <= 1'b0;
        while (sent < n_words || returned < sent) begin
            @(posedge clk);
            if (in_credit) begin
                host_credits++;
                returned++;
            end
            assert (host_credits <= in_credits)
                else note_failure("in_credit returned a credit that was never spent");
            if (sent < n_words && host_credits > 0) begin
                w    = data_width'($urandom);
                slot = bank0 + sent / slice_words;
                model[slot % para_y][(row0 + slot / para_y) % bank_depth][sent % slice_words] = w;
                in_valid <= 1'b1;
                in_data  <= w;
                host_credits--;
                sent++;
            end else begin
                in_valid <= 1'b0;
            end
        end
        repeat (4) begin
            @(posedge clk);
            if (in_credit) extra++;
        end
        assert (returned == n_words && extra == 0)
            else note_failure($sformatf("%0d credits came back for %0d words", returned + extra,
                                        n_words));
        assert (host_credits == in_credits) else note_failure("host did not get all credits back");
    endtask

    // one read command, beats checked in order; credits held back for hold_cycles
    task automatic run_command(input logic cmd_mode, input int ks, input int row,
                               input int total, input int hold_cycles);
        int  n_exp;
        int  beats;
        int  owed;
        int  cyc;
        int  held_beats;
        bit  seen_last;
        bit  busy_done;
        logic [beat_width-1:0] exp_beat;
        n_exp      = (cmd_mode == mode_conv) ? ks * ks : ((total == 0) ? 1 : total);
        beats      = 0;
        owed       = 0;
        cyc        = 0;
        held_beats = 0;
        seen_last  = 1'b0;
        busy_done  = 1'b0;
        @(posedge clk);
        while (busy) @(posedge clk);
        start         <= 1'b1;
        mode          <= cmd_mode;
        kernel_size   <= ks_width'(ks);
        base_row      <= row_width'(row);
        fm_total_size <= fm_size_width'(total);
        @(posedge clk);
        start <= 1'b0;
        while (!busy_done || owed > 0) begin
            @(posedge clk);
            cyc++;
            if (seen_last && !busy_done) begin
                assert (!busy) else note_failure("busy still high the cycle after the last beat");
                busy_done = 1'b1;
            end
            if (out_valid) begin
                if (beats < n_exp) begin
                    exp_beat = expected_beat(cmd_mode, ks, row, total, beats);
                    assert (out_data === exp_beat)
                        else note_mismatch("out_data", out_data, exp_beat);
                    assert (out_last === (beats == n_exp - 1))
                        else note_mismatch("out_last", beat_width'(out_last),
                                           beat_width'(beats == n_exp - 1));
                    beats_checked++;
                end else begin
                    note_failure("beat arrived after the last one");
                end
                if (out_last) seen_last = 1'b1;
                if (cyc <= hold_cycles) held_beats++;
                beats++;
                owed++;
            end
            if (owed > 0 && cyc > hold_cycles) begin
                out_credit <= 1'b1;   // one credit back per beat taken
                owed--;
            end else begin
                out_credit <= 1'b0;
            end
        end
        @(posedge clk);
        out_credit <= 1'b0;
        assert (beats == n_exp) else note_failure($sformatf("%0d beats, %0d wanted", beats, n_exp));
        if (hold_cycles > 0) begin
            assert (held_beats == ((n_exp < out_credits) ? n_exp : out_credits))
                else note_failure($sformatf("%0d beats while credits were held", held_beats));
        end
    endtask

    task automatic check_load_credits;
        tests_run++;
        load_slices(8, 0, 0);  // rows 0 and 1 of all banks
    endtask

    task automatic read_conv_full;
        tests_run++;
        run_command(mode_conv, 3, 0, 0, 0);
    endtask

    task automatic read_conv_small;
        tests_run++;
        run_command(mode_conv, 2, 0, 0, 0);
        run_command(mode_conv, 1, 1, 0, 0);
    endtask

    task automatic walk_fc;
        tests_run++;
        run_command(mode_fc, 3, 0, 13, 0);
        run_command(mode_fc, 3, 0, 0, 0);   // zero length gives one all-zero beat
    endtask

    task automatic hold_out_credits;
        tests_run++;
        run_command(mode_conv, 3, 1, 0, 20);
        run_command(mode_fc, 3, 0, 13, 12);
    endtask

    task automatic collide_write_read;
        int stalls_before;
        tests_run++;
        stalls_before = stall_count;
        fork
            load_slices(4, 2, 0);
            repeat (6) run_command(mode_conv, 3, 1, 0, 0);
        join
        assert (stall_count > stalls_before) else note_failure("no write ever met a read");
        run_command(mode_conv, 3, 2, 0, 0);   // the freshly written row
    endtask

    initial begin
        void'($urandom(65));
        in_valid      = 1'b0;
        in_data       = '0;
        load_start    = 1'b0;
        wr_base_row   = '0;
        wr_base_bank  = '0;
        start         = 1'b0;
        mode          = mode_conv;
        kernel_size   = ks_width'(1);
        base_row      = '0;
        fm_total_size = '0;
        out_credit    = 1'b0;
        host_credits  = in_credits;
        wait (arst_n === 1'b1);
        @(posedge clk);
        assert (!in_credit && !uut.wr_en && !uut.rd_en && !out_valid && !out_last && !busy)
            else note_failure("outputs not low after reset");
        check_load_credits();
        read_conv_full();
        read_conv_small();
        walk_fc();
        hold_out_credits();
        collide_write_read();
        $display("tests %0d, beats checked %0d, errors %0d", tests_run, beats_checked, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
common/cnn_pkg.sv
weight_ram/weight_ram_float16.sv
weight_ram/weight_loader.sv
rtl/weight_issue.sv
rtl/weight_buffer_top.sv
tests/clk_gen.sv
tests/weight_buffer_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the weight buffer testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module weight_buffer_tb -f filelist.f \
    --Mdir obj_dir -o sim_weight_buffer

./obj_dir/sim_weight_buffer 2>&1 | tee "$LOG"

if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
    echo "simulation failed, see $LOG"
    exit 1
fi
echo "simulation passed"
